// File: hdl/lsu_pkg.sv
package lsu_pkg;

  localparam int DATA_WIDTH = 32;  // rv32 data and address width

  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_e;

  // access size and signedness, same as the funct3 field of the instruction
  localparam logic [2:0] F3_B  = 3'b000;  // lb / sb
  localparam logic [2:0] F3_H  = 3'b001;  // lh / sh
  localparam logic [2:0] F3_W  = 3'b010;  // lw / sw
  localparam logic [2:0] F3_BU = 3'b100;  // lbu
  localparam logic [2:0] F3_HU = 3'b101;  // lhu

  typedef struct packed {
    lsu_op_e               op;
    logic [2:0]            funct3;
    logic [DATA_WIDTH-1:0] addr;    // effective address from execute
    logic [DATA_WIDTH-1:0] wdata;   // rs2
  } lsu_req_t;

endpackage

// File: hdl/mem_pkg.sv
package mem_pkg;

  localparam int MEM_WORDS       = 256;
  localparam int WORD_ADDR_WIDTH = $clog2(MEM_WORDS);   // 8
  localparam int BE_WIDTH        = lsu_pkg::DATA_WIDTH / 8;

  typedef struct packed {
    logic                           re;
    logic                           we;
    logic [BE_WIDTH-1:0]            be;         // one bit per byte lane
    logic [WORD_ADDR_WIDTH-1:0]     word_addr;
    logic [lsu_pkg::DATA_WIDTH-1:0] wdata;      // already lane aligned
  } mem_req_t;

endpackage

// File: hdl/lsu_store_align.sv
module lsu_store_align (
  input  logic [2:0]                     funct3,
  input  logic [1:0]                     offset,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] wdata,
  output logic [lsu_pkg::DATA_WIDTH-1:0] wdata_lane,
  output logic [mem_pkg::BE_WIDTH-1:0]   be
);

  import lsu_pkg::*;
  import mem_pkg::*;

  logic [BE_WIDTH-1:0] be_base;

  // replicate the store data so every legal offset finds it in its lane
  always_comb begin
    case (funct3)
      F3_B: begin
        wdata_lane = {4{wdata[7:0]}};
        be_base    = 4'b0001;
      end
      F3_H: begin
        wdata_lane = {2{wdata[15:0]}};
        be_base    = 4'b0011;
      end
      F3_W: begin
        wdata_lane = wdata;
        be_base    = 4'b1111;
      end
      default: begin
        wdata_lane = wdata;
        be_base    = '0;       // unsupported, nothing written
      end
    endcase
  end

  // move the enables to the addressed lane
  // misaligned halfwords and words are dropped in lsu, so no lane wraps here
  always_comb begin
    be = be_base << offset;
  end

endmodule

// File: hdl/lsu_load_extend.sv
module lsu_load_extend (
  input  logic [2:0]                     funct3,
  input  logic [1:0]                     offset,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] rdata,
  output logic [lsu_pkg::DATA_WIDTH-1:0] result
);

  import lsu_pkg::*;

  logic [DATA_WIDTH-1:0] shifted;

  // bring the addressed lane down to bit 0
  always_comb begin
    shifted = rdata >> {offset, 3'b000};
  end

  always_comb begin
    case (funct3)
      F3_B:    result = {{(DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};      // lb
      F3_H:    result = {{(DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};   // lh
      F3_W:    result = rdata;                                              // lw
      F3_BU:   result = {{(DATA_WIDTH-8){1'b0}}, shifted[7:0]};             // lbu
      F3_HU:   result = {{(DATA_WIDTH-16){1'b0}}, shifted[15:0]};           // lhu
      default: result = '0;
    endcase
  end

endmodule

// File: hdl/data_ram.sv
module data_ram (
  input  logic                           clk,
  input  mem_pkg::mem_req_t              mem_req,
  output logic [lsu_pkg::DATA_WIDTH-1:0] rdata
);

  import lsu_pkg::*;
  import mem_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic [DATA_WIDTH-1:0] cur_word;
  logic [DATA_WIDTH-1:0] merged;

  always_comb begin
    cur_word = mem[mem_req.word_addr];
  end

  // word after this cycle's write, used for both the array and the read
  always_comb begin
    merged = cur_word;
    for (int i = 0; i < BE_WIDTH; i++) begin
      if (mem_req.we && mem_req.be[i]) begin
        merged[i*8 +: 8] = mem_req.wdata[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req.we) begin
      mem[mem_req.word_addr] <= merged;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req.re) begin
      rdata <= merged;     // write-first
    end
  end

endmodule

// File: hdl/lsu.sv
module lsu (
  input  logic                           clk,
  input  logic                           arst_n,
  input  lsu_pkg::lsu_req_t              req,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] rdata,
  output mem_pkg::mem_req_t              mem_req,
  output logic [lsu_pkg::DATA_WIDTH-1:0] lsu_result,
  output logic                           result_valid,
  output logic                           misaligned
);

  import lsu_pkg::*;
  import mem_pkg::*;

  logic                  is_load;
  logic                  is_store;
  logic                  ld_f3_ok;
  logic                  st_f3_ok;
  logic                  align_ok;
  logic                  legal_load;
  logic                  legal_store;
  logic [1:0]            offset;
  logic [DATA_WIDTH-1:0] wdata_lane;
  logic [BE_WIDTH-1:0]   st_be;
  logic [DATA_WIDTH-1:0] ext_result;

  // load context travelling with the ram read
  logic                  ld_valid_q;
  logic [2:0]            ld_funct3_q;
  logic [1:0]            ld_offset_q;

  assign is_load  = (req.op == LSU_LOAD);
  assign is_store = (req.op == LSU_STORE);
  assign offset   = req.addr[1:0];

  always_comb begin
    ld_f3_ok = 1'b0;
    st_f3_ok = 1'b0;
    align_ok = 1'b0;
    case (req.funct3)
      F3_B: begin
        ld_f3_ok = 1'b1;
        st_f3_ok = 1'b1;
        align_ok = 1'b1;
      end
      F3_H: begin
        ld_f3_ok = 1'b1;
        st_f3_ok = 1'b1;
        align_ok = ~offset[0];
      end
      F3_W: begin
        ld_f3_ok = 1'b1;
        st_f3_ok = 1'b1;
        align_ok = (offset == 2'b00);
      end
      F3_BU: begin
        ld_f3_ok = 1'b1;    // no sbu
        align_ok = 1'b1;
      end
      F3_HU: begin
        ld_f3_ok = 1'b1;
        align_ok = ~offset[0];
      end
      default: ;            // unsupported for both
    endcase
  end

  assign misaligned  = (is_load && !(ld_f3_ok && align_ok)) ||
                       (is_store && !(st_f3_ok && align_ok));
  assign legal_load  = is_load && !misaligned;
  assign legal_store = is_store && !misaligned;

  lsu_store_align i_store_align (
    .funct3     (req.funct3),
    .offset     (offset),
    .wdata      (req.wdata),
    .wdata_lane (wdata_lane),
    .be         (st_be)
  );

  always_comb begin
    mem_req.re        = legal_load;
    mem_req.we        = legal_store;
    mem_req.be        = st_be;
    mem_req.word_addr = req.addr[WORD_ADDR_WIDTH+1:2];   // wraps over the ram
    mem_req.wdata     = wdata_lane;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ld_valid_q <= 1'b0;
    end else begin
      ld_valid_q <= legal_load;
    end
  end

  always_ff @(posedge clk) begin
    if (legal_load) begin
      ld_funct3_q <= req.funct3;
      ld_offset_q <= offset;
    end
  end

  lsu_load_extend i_load_extend (
    .funct3 (ld_funct3_q),
    .offset (ld_offset_q),
    .rdata  (rdata),
    .result (ext_result)
  );

  assign result_valid = ld_valid_q;
  assign lsu_result   = ld_valid_q ? ext_result : '0;   // quiet between pulses

endmodule

// File: hdl/lsu_top.sv
module lsu_top (
  input  logic                           clk,
  input  logic                           arst_n,
  input  lsu_pkg::lsu_req_t              req,
  output logic [lsu_pkg::DATA_WIDTH-1:0] lsu_result,
  output logic                           result_valid,
  output logic                           misaligned
);

  import mem_pkg::*;

  mem_req_t                       mem_req;
  logic [lsu_pkg::DATA_WIDTH-1:0] rdata;

  lsu i_lsu (
    .clk          (clk),
    .arst_n       (arst_n),
    .req          (req),
    .rdata        (rdata),
    .mem_req      (mem_req),
    .lsu_result   (lsu_result),
    .result_valid (result_valid),
    .misaligned   (misaligned)
  );

  data_ram i_data_ram (
    .clk     (clk),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

endmodule

// File: sim/lsu_top_sva.sv
module lsu_top_sva (
  input  logic                           clk,
  input  logic                           arst_n,
  input  lsu_pkg::lsu_req_t              req,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] lsu_result,
  input  logic                           result_valid,
  input  logic                           misaligned
);

  import lsu_pkg::*;
  import mem_pkg::*;

  logic [7:0]                 shadow [MEM_WORDS*4];   // byte image of the ram
  logic [WORD_ADDR_WIDTH+1:0] byte_idx;
  logic [7:0]                 lo_byte;
  logic [7:0]                 hi_byte;
  logic                       exp_mis;
  logic                       load_ok;
  logic                       store_ok;
  logic [DATA_WIDTH-1:0]      exp_now;
  logic [DATA_WIDTH-1:0]      exp_q;
  logic                       exp_valid_q;
  int                         fail_count = 0;

  assign byte_idx = req.addr[WORD_ADDR_WIDTH+1:0];   // wraps like the ram

  always_comb begin
    exp_mis = 1'b0;
    if (req.op == LSU_LOAD) begin
      case (req.funct3)
        F3_B, F3_BU: exp_mis = 1'b0;
        F3_H, F3_HU: exp_mis = req.addr[0];
        F3_W:        exp_mis = |req.addr[1:0];
        default:     exp_mis = 1'b1;   // 011, 110, 111
      endcase
    end else if (req.op == LSU_STORE) begin
      case (req.funct3)
        F3_B:    exp_mis = 1'b0;
        F3_H:    exp_mis = req.addr[0];
        F3_W:    exp_mis = |req.addr[1:0];
        default: exp_mis = 1'b1;
      endcase
    end
  end

  assign load_ok  = (req.op == LSU_LOAD) && !exp_mis;
  assign store_ok = (req.op == LSU_STORE) && !exp_mis;

  always_comb begin
    lo_byte = shadow[byte_idx];
    hi_byte = shadow[byte_idx + 1'b1];
    case (req.funct3)
      F3_B:    exp_now = {{24{lo_byte[7]}}, lo_byte};
      F3_H:    exp_now = {{16{hi_byte[7]}}, hi_byte, lo_byte};
      F3_W:    exp_now = {shadow[byte_idx + 2'd3], shadow[byte_idx + 2'd2], hi_byte, lo_byte};
      F3_BU:   exp_now = {24'b0, lo_byte};
      F3_HU:   exp_now = {16'b0, hi_byte, lo_byte};
      default: exp_now = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (store_ok) begin
      shadow[byte_idx] <= req.wdata[7:0];
      if (req.funct3 != F3_B) begin
        shadow[byte_idx + 1'b1] <= req.wdata[15:8];
      end
      if (req.funct3 == F3_W) begin
        shadow[byte_idx + 2'd2] <= req.wdata[23:16];
        shadow[byte_idx + 2'd3] <= req.wdata[31:24];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_valid_q <= 1'b0;
      exp_q       <= '0;
    end else begin
      exp_valid_q <= load_ok;
      if (load_ok) begin
        exp_q <= exp_now;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    $rose(arst_n) |-> (result_valid === 1'b0) && (lsu_result === '0))
    else begin
      $error("outputs not quiet after reset release");
      fail_count++;
    end

  a_misaligned: assert property (@(posedge clk) disable iff (!arst_n)
    misaligned === exp_mis)
    else begin
      $error("misaligned flag does not match the request");
      fail_count++;
    end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid === exp_valid_q)
    else begin
      $error("result_valid not one cycle after a legal load");
      fail_count++;
    end

  a_no_pulse_rejected: assert property (@(posedge clk) disable iff (!arst_n)
    exp_mis |=> !result_valid)
    else begin
      $error("rejected request produced a result");
      fail_count++;
    end

  a_load_data: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |-> lsu_result === exp_q)
    else begin
      $error("load data differs from shadow memory");
      fail_count++;
    end

  a_idle_zero: assert property (@(posedge clk) disable iff (!arst_n)
    !result_valid |-> lsu_result === '0)
    else begin
      $error("lsu_result not zero between pulses");
      fail_count++;
    end

endmodule

bind lsu_top lsu_top_sva i_sva (
  .clk          (clk),
  .arst_n       (arst_n),
  .req          (req),
  .lsu_result   (lsu_result),
  .result_valid (result_valid),
  .misaligned   (misaligned)
);

// File: sim/tb_lsu_top.sv
module tb_lsu_top;

  import lsu_pkg::*;

  localparam int RESET_CYCLES    = 5;
  localparam int FILL_WORDS      = 16;
  localparam int DIRECTED_CYCLES = 100;
  localparam int RANDOM_REQS     = 300;
  localparam int SLACK_CYCLES    = 179;
  localparam int MAX_CYCLES      = RESET_CYCLES + FILL_WORDS + DIRECTED_CYCLES +
                                   RANDOM_REQS + SLACK_CYCLES;   // 600
  localparam int RESULT_WAIT     = 4;

  logic                  clk;
  logic                  arst_n;
  lsu_req_t              req;
  logic [DATA_WIDTH-1:0] lsu_result;
  logic                  result_valid;
  logic                  misaligned;
  logic [31:0]           lcg_state;
  int                    cycle_count = 0;
  int                    check_errs = 0;
  int                    timeout_errs = 0;

  lsu_top i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .req          (req),
    .lsu_result   (lsu_result),
    .result_valid (result_valid),
    .misaligned   (misaligned)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic send(input lsu_op_e op, input logic [2:0] f3, input logic [31:0] addr,
                      input logic [31:0] wdata);
    req.op     = op;
    req.funct3 = f3;
    req.addr   = addr;
    req.wdata  = wdata;
    @(posedge clk);
    #1;
  endtask

  task automatic load_check(input logic [2:0] f3, input logic [31:0] addr,
                            input logic [31:0] expected);
    int waited;
    send(LSU_LOAD, f3, addr, '0);
    req.op = LSU_NONE;
    waited = 0;
    while (!result_valid && waited < RESULT_WAIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!result_valid) begin
      $display("load from 0x%08h never returned a result", addr);
      timeout_errs++;
    end else if (lsu_result !== expected) begin
      $display("FAILED %0t: load f3=%0d at 0x%08h gave 0x%08h, expected 0x%08h",
               $time, f3, addr, lsu_result, expected);
      check_errs++;
    end
  endtask

  task automatic check_rejected(input lsu_op_e op, input logic [2:0] f3,
                                input logic [31:0] addr, input logic [31:0] wdata);
    req.op     = op;
    req.funct3 = f3;
    req.addr   = addr;
    req.wdata  = wdata;
    #2;
    if (misaligned !== 1'b1) begin
      $display("FAILED %0t: %s f3=%0d at 0x%08h not flagged misaligned",
               $time, op.name(), f3, addr);
      check_errs++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic print_summary();
    $display("errors: checks %0d, timeouts %0d, assertions %0d",
             check_errs, timeout_errs, i_dut.i_sva.fail_count);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      timeout_errs++;
      $display("run stopped after %0d cycles without finishing", cycle_count);
      print_summary();
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] r;
    lsu_op_e     op;
    logic [2:0]  f3;
    arst_n    = 1'b0;
    req       = '0;
    lcg_state = 32'd70;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    if (result_valid !== 1'b0 || lsu_result !== '0) begin
      $display("FAILED %0t: outputs not zero after reset", $time);
      check_errs++;
    end

    // words 0..15 hold the random phase traffic
    for (int w = 0; w < FILL_WORDS; w++) begin
      addr = w * 4;
      send(LSU_STORE, F3_W, addr, {~addr[15:0], addr[15:0]});
    end

    send(LSU_STORE, F3_W, 32'h0000_0100, 32'h80F1_7F85);
    load_check(F3_B,  32'h0000_0100, 32'hFFFF_FF85);
    load_check(F3_BU, 32'h0000_0100, 32'h0000_0085);
    load_check(F3_B,  32'h0000_0101, 32'h0000_007F);
    load_check(F3_B,  32'h0000_0103, 32'hFFFF_FF80);
    load_check(F3_H,  32'h0000_0100, 32'h0000_7F85);
    load_check(F3_H,  32'h0000_0102, 32'hFFFF_80F1);
    load_check(F3_HU, 32'h0000_0102, 32'h0000_80F1);
    load_check(F3_W,  32'h0000_0100, 32'h80F1_7F85);

    // partial writes keep the other lanes
    send(LSU_STORE, F3_B, 32'h0000_0101, 32'h1234_563C);
    send(LSU_STORE, F3_H, 32'h0000_0102, 32'hDEAD_BEEF);
    load_check(F3_W,  32'h0000_0100, 32'hBEEF_3C85);
    load_check(F3_HU, 32'h0000_0100, 32'h0000_3C85);

    check_rejected(LSU_STORE, F3_W,   32'h0000_0101, 32'hFFFF_FFFF);
    check_rejected(LSU_STORE, F3_H,   32'h0000_0103, 32'hFFFF_FFFF);
    check_rejected(LSU_LOAD,  F3_H,   32'h0000_0101, '0);
    check_rejected(LSU_LOAD,  F3_W,   32'h0000_0102, '0);
    check_rejected(LSU_LOAD,  3'b011, 32'h0000_0100, '0);
    check_rejected(LSU_STORE, F3_BU,  32'h0000_0100, 32'h0000_0000);
    check_rejected(LSU_STORE, 3'b111, 32'h0000_0100, 32'h0000_0000);
    load_check(F3_W, 32'h0000_0100, 32'hBEEF_3C85);

    // back to back, checked by the bound assertions
    send(LSU_LOAD, F3_B,  32'h0000_0100, '0);
    send(LSU_LOAD, F3_HU, 32'h0000_0102, '0);
    send(LSU_LOAD, F3_W,  32'h0000_0100, '0);
    send(LSU_LOAD, F3_BU, 32'h0000_0103, '0);
    send(LSU_NONE, F3_B,  '0, '0);

    // load right behind a store, upper bits wrap
    send(LSU_STORE, F3_W, 32'h0000_0104, 32'h1357_9BDF);
    load_check(F3_W,  32'h8000_0104, 32'h1357_9BDF);
    send(LSU_STORE, F3_B, 32'h0000_0105, 32'h0000_0042);
    load_check(F3_BU, 32'h0000_0105, 32'h0000_0042);
    load_check(F3_H,  32'hFFF0_0104, 32'h0000_42DF);

    for (int i = 0; i < RANDOM_REQS; i++) begin
      r = next_rand();
      case (r[31:30])
        2'd0:    op = LSU_NONE;
        2'd2:    op = LSU_STORE;
        default: op = LSU_LOAD;
      endcase
      f3   = r[29:27];
      addr = next_rand() & 32'hFFFF_FC3F;   // words 0..15 only
      send(op, f3, addr, next_rand());
    end

    req = '0;
    repeat (3) @(posedge clk);
    #1;
    print_summary();
    if (check_errs == 0 && timeout_errs == 0 && i_dut.i_sva.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: project.f
hdl/lsu_pkg.sv
hdl/mem_pkg.sv
hdl/lsu_store_align.sv
hdl/lsu_load_extend.sv
hdl/data_ram.sv
hdl/lsu.sv
hdl/lsu_top.sv
sim/lsu_top_sva.sv
sim/tb_lsu_top.sv
